//--- nunchuk_defines.svh
`ifndef NUNCHUK_DEFINES_SVH
`define NUNCHUK_DEFINES_SVH

// 7-bit bus address of the Nunchuk
`define NUNCHUK_ADDR 7'h52

// clk cycles per quarter of an I2C bit
`define I2C_CLK_DIV 4

// Command slots in one program
`define CMD_SLOTS 16

// Data bytes returned by one read program
`define READ_BYTES 6

`endif

//--- i2c_pkg.sv
package i2c_pkg;

	// Command held in one slot of a program
	typedef enum logic [2:0] {
		IDLE_CMD,
		START,
		STOP,
		WRITE_BYTE,
		READ_BYTE_ACK,
		READ_BYTE_NACK
	} i2c_cmd_t;

	// Bit engine states of the master
	typedef enum logic [2:0] {
		PH_FETCH,
		PH_START,
		PH_STOP,
		PH_DATA,
		PH_ACK,
		PH_NEXT
	} i2c_phase_t;

endpackage

//--- nunchuk_pkg.sv
package nunchuk_pkg;

	// Program currently run by the sequencer
	typedef enum logic [1:0] {
		HANDSHAKE1,
		HANDSHAKE2,
		DUMMY_WRITE,
		READING
	} seq_state_t;

	// Joystick axes are plain bytes
	localparam int JOY_W = 8;

	// Accelerometer axes carry two extra low bits from the last byte
	localparam int ACC_W = 10;

endpackage

//--- i2c_master.sv
`include "nunchuk_defines.svh"

module i2c_master
	import i2c_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  i2c_cmd_t   cmd,
	input  logic [7:0] wr_byte,
	input  logic       sda_in,
	output logic [3:0] slot,
	output logic [7:0] rd_byte,
	output logic       rd_valid,
	output logic       done,
	output logic       nack_err,
	output logic       scl,
	output logic       sda_low
);

	localparam int DIV_W = $clog2(`I2C_CLK_DIV + 1);
	localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`I2C_CLK_DIV - 1);
	localparam logic [3:0] SLOT_LAST = 4'(`CMD_SLOTS - 1);

	i2c_phase_t phase;
	logic [DIV_W-1:0] div_cnt;
	logic tick;
	logic [1:0] quarter;
	logic [2:0] bit_cnt;
	logic [7:0] shift;
	logic is_read;
	logic send_nack;
	logic fetch;

	assign tick = (div_cnt == DIV_LAST);

	// A new command is taken once the done pulse of the last program is over
	assign fetch = (phase == PH_FETCH) && !done;

	always_ff @(posedge clk) begin
		if (rst || phase == PH_FETCH || phase == PH_NEXT) begin
			div_cnt <= '0;
		end else if (tick) begin
			div_cnt <= '0;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			phase    <= PH_FETCH;
			quarter  <= 2'd0;
			bit_cnt  <= 3'd0;
			slot     <= 4'd0;
			done     <= 1'b0;
			rd_valid <= 1'b0;
			nack_err <= 1'b0;
			scl      <= 1'b1;
			sda_low  <= 1'b0;
		end else begin
			done     <= 1'b0;
			rd_valid <= 1'b0;
			case (phase)
				PH_FETCH: begin
					if (fetch) begin
						// Error flag covers one program only
						if (slot == 4'd0)
							nack_err <= 1'b0;
						quarter <= 2'd0;
						bit_cnt <= 3'd0;
						case (cmd)
							START:       phase <= PH_START;
							STOP:        phase <= PH_STOP;
							WRITE_BYTE,
							READ_BYTE_ACK,
							READ_BYTE_NACK: phase <= PH_DATA;
							default: begin
								done <= 1'b1;
								slot <= 4'd0;
							end
						endcase
					end
				end
				PH_START: begin
					if (tick) begin
						// Also works as repeated start, scl may be low on entry
						case (quarter)
							2'd0: sda_low <= 1'b0;
							2'd1: scl <= 1'b1;
							2'd2: sda_low <= 1'b1;
							default: begin
								scl   <= 1'b0;
								phase <= PH_NEXT;
							end
						endcase
						quarter <= quarter + 2'd1;
					end
				end
				PH_STOP: begin
					if (tick) begin
						case (quarter)
							2'd0: begin
								scl     <= 1'b0;
								sda_low <= 1'b1;
							end
							2'd1: scl <= 1'b1;
							2'd2: sda_low <= 1'b0;
							default: phase <= PH_NEXT;
						endcase
						quarter <= quarter + 2'd1;
					end
				end
				PH_DATA: begin
					if (tick) begin
						case (quarter)
							2'd0: begin
								scl     <= 1'b0;
								sda_low <= !is_read && !shift[7];
							end
							2'd1: scl <= 1'b1;
							2'd2: ;
							default: begin
								scl <= 1'b0;
								if (bit_cnt == 3'd7)
									phase <= PH_ACK;
								bit_cnt <= bit_cnt + 3'd1;
							end
						endcase
						quarter <= quarter + 2'd1;
					end
				end
				PH_ACK: begin
					if (tick) begin
						case (quarter)
							2'd0: sda_low <= is_read && !send_nack;
							2'd1: scl <= 1'b1;
							2'd2: begin
								if (!is_read && sda_in)
									nack_err <= 1'b1;
							end
							default: begin
								scl      <= 1'b0;
								rd_valid <= is_read;
								phase    <= PH_NEXT;
							end
						endcase
						quarter <= quarter + 2'd1;
					end
				end
				default: begin
					if (slot == SLOT_LAST) begin
						done <= 1'b1;
						slot <= 4'd0;
					end else begin
						slot <= slot + 4'd1;
					end
					phase <= PH_FETCH;
				end
			endcase
		end
	end

	// Byte datapath
	always_ff @(posedge clk) begin
		if (fetch) begin
			shift     <= wr_byte;
			is_read   <= (cmd == READ_BYTE_ACK) || (cmd == READ_BYTE_NACK);
			send_nack <= (cmd == READ_BYTE_NACK);
		end else if (tick && phase == PH_DATA && quarter == 2'd2) begin
			shift <= {shift[6:0], sda_in};
		end
		if (tick && phase == PH_ACK && quarter == 2'd3 && is_read)
			rd_byte <= shift;
	end

endmodule

//--- nunchuk_sequencer.sv
`include "nunchuk_defines.svh"

module nunchuk_sequencer
	import i2c_pkg::*;
	import nunchuk_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  logic [3:0] slot,
	input  logic       done,
	input  logic       nack_err,
	output i2c_cmd_t   cmd,
	output logic [7:0] wr_byte,
	output seq_state_t state
);

	localparam logic [7:0] ADDR_WR = {`NUNCHUK_ADDR, 1'b0};
	localparam logic [7:0] ADDR_RD = {`NUNCHUK_ADDR, 1'b1};

	seq_state_t next_state;

	always_ff @(posedge clk) begin
		if (rst)
			state <= HANDSHAKE1;
		else if (done)
			state <= nack_err ? HANDSHAKE1 : next_state;
	end

	always_comb begin
		case (state)
			HANDSHAKE1:  next_state = HANDSHAKE2;
			HANDSHAKE2:  next_state = DUMMY_WRITE;
			default:     next_state = READING;
		endcase
	end

	// Command tables
	always_comb begin
		cmd = IDLE_CMD;
		case (state)
			HANDSHAKE1, HANDSHAKE2: begin
				case (slot)
					4'd0:             cmd = START;
					4'd1, 4'd2, 4'd3: cmd = WRITE_BYTE;
					4'd4:             cmd = STOP;
					default:          cmd = IDLE_CMD;
				endcase
			end
			default: begin
				// Register 0 write, repeated start, then six reads
				case (slot)
					4'd0, 4'd3:       cmd = START;
					4'd1, 4'd2, 4'd4: cmd = WRITE_BYTE;
					4'd5, 4'd6, 4'd7,
					4'd8, 4'd9:       cmd = READ_BYTE_ACK;
					4'd10:            cmd = READ_BYTE_NACK;
					4'd11:            cmd = STOP;
					default:          cmd = IDLE_CMD;
				endcase
			end
		endcase
	end

	// Write byte tables
	always_comb begin
		wr_byte = 8'h00;
		case (state)
			HANDSHAKE1: begin
				case (slot)
					4'd1:    wr_byte = ADDR_WR;
					4'd2:    wr_byte = 8'hf0;
					4'd3:    wr_byte = 8'h55;
					default: wr_byte = 8'h00;
				endcase
			end
			HANDSHAKE2: begin
				case (slot)
					4'd1:    wr_byte = ADDR_WR;
					4'd2:    wr_byte = 8'hfb;
					default: wr_byte = 8'h00;
				endcase
			end
			default: begin
				case (slot)
					4'd1:    wr_byte = ADDR_WR;
					4'd4:    wr_byte = ADDR_RD;
					default: wr_byte = 8'h00;
				endcase
			end
		endcase
	end

endmodule

//--- nunchuk_decoder.sv
`include "nunchuk_defines.svh"

module nunchuk_decoder
	import nunchuk_pkg::*;
(
	input  logic             clk,
	input  logic             rst,
	input  logic [7:0]       rd_byte,
	input  logic             rd_valid,
	input  logic             done,
	input  seq_state_t       state,
	output logic [JOY_W-1:0] joy_x,
	output logic [JOY_W-1:0] joy_y,
	output logic [ACC_W-1:0] acc_x,
	output logic [ACC_W-1:0] acc_y,
	output logic [ACC_W-1:0] acc_z,
	output logic             button_c,
	output logic             button_z,
	output logic             sample_valid
);

	localparam int CNT_W = $clog2(`READ_BYTES + 1);
	localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(`READ_BYTES);

	logic [7:0] bytes [`READ_BYTES];
	logic [CNT_W-1:0] count;
	logic read_prog;

	assign read_prog = (state == DUMMY_WRITE) || (state == READING);

	always_ff @(posedge clk) begin
		if (rst) begin
			count        <= '0;
			sample_valid <= 1'b0;
		end else begin
			sample_valid <= done && read_prog && (count == CNT_FULL);
			if (done)
				count <= '0;
			else if (rd_valid && count != CNT_FULL)
				count <= count + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (rd_valid && count != CNT_FULL)
			bytes[count] <= rd_byte;
	end

	// Byte 5 packs the low accel bits and the active low buttons
	always_ff @(posedge clk) begin
		if (done && read_prog && count == CNT_FULL) begin
			joy_x    <= bytes[0];
			joy_y    <= bytes[1];
			acc_x    <= {bytes[2], bytes[5][3:2]};
			acc_y    <= {bytes[3], bytes[5][5:4]};
			acc_z    <= {bytes[4], bytes[5][7:6]};
			button_c <= ~bytes[5][1];
			button_z <= ~bytes[5][0];
		end
	end

endmodule

//--- nunchuk_top.sv
module nunchuk_top
	import i2c_pkg::*;
	import nunchuk_pkg::*;
(
	input  logic             clk,
	input  logic             rst,
	input  logic             sda_in,
	output logic             scl,
	output logic             sda_low,
	output logic [JOY_W-1:0] joy_x,
	output logic [JOY_W-1:0] joy_y,
	output logic [ACC_W-1:0] acc_x,
	output logic [ACC_W-1:0] acc_y,
	output logic [ACC_W-1:0] acc_z,
	output logic             button_c,
	output logic             button_z,
	output logic             sample_valid
);

	i2c_cmd_t   cmd;
	logic [7:0] wr_byte;
	logic [3:0] slot;
	logic [7:0] rd_byte;
	logic       rd_valid;
	logic       done;
	logic       nack_err;
	seq_state_t state;

	i2c_master u_master (
		.clk      (clk),
		.rst      (rst),
		.cmd      (cmd),
		.wr_byte  (wr_byte),
		.sda_in   (sda_in),
		.slot     (slot),
		.rd_byte  (rd_byte),
		.rd_valid (rd_valid),
		.done     (done),
		.nack_err (nack_err),
		.scl      (scl),
		.sda_low  (sda_low)
	);

	nunchuk_sequencer u_sequencer (
		.clk      (clk),
		.rst      (rst),
		.slot     (slot),
		.done     (done),
		.nack_err (nack_err),
		.cmd      (cmd),
		.wr_byte  (wr_byte),
		.state    (state)
	);

	nunchuk_decoder u_decoder (
		.clk          (clk),
		.rst          (rst),
		.rd_byte      (rd_byte),
		.rd_valid     (rd_valid),
		.done         (done),
		.state        (state),
		.joy_x        (joy_x),
		.joy_y        (joy_y),
		.acc_x        (acc_x),
		.acc_y        (acc_y),
		.acc_z        (acc_z),
		.button_c     (button_c),
		.button_z     (button_z),
		.sample_valid (sample_valid)
	);

endmodule

//--- nunchuk_model.sv
`include "nunchuk_defines.svh"

module nunchuk_model (
	input  logic       clk,
	input  logic       rst,
	input  logic       scl,
	input  logic       sda,
	input  logic       present,
	input  logic [7:0] data [`READ_BYTES],
	output logic       sda_low,
	output logic       wr_valid,
	output logic [7:0] wr_data,
	output int         read_progs
);

	localparam logic [2:0] BYTE_END = 3'(`READ_BYTES);

	logic scl_q;
	logic sda_q;
	logic active;
	logic addr_phase;
	logic tx;
	logic master_ack;
	logic [3:0] bit_cnt;
	logic [7:0] shift;
	logic [2:0] rd_idx;

	always_ff @(posedge clk) begin
		if (rst) begin
			scl_q      <= 1'b1;
			sda_q      <= 1'b1;
			active     <= 1'b0;
			addr_phase <= 1'b0;
			tx         <= 1'b0;
			master_ack <= 1'b0;
			bit_cnt    <= 4'd0;
			shift      <= 8'h00;
			rd_idx     <= 3'd0;
			sda_low    <= 1'b0;
			wr_valid   <= 1'b0;
			wr_data    <= 8'h00;
			read_progs <= 0;
		end else begin
			scl_q    <= scl;
			sda_q    <= sda;
			wr_valid <= 1'b0;
			if (scl && scl_q && sda_q && !sda) begin
				// Start or repeated start
				active     <= 1'b1;
				addr_phase <= 1'b1;
				tx         <= 1'b0;
				// The scl fall that ends the start wraps the count to zero
				bit_cnt    <= 4'd15;
				sda_low    <= 1'b0;
			end else if (scl && scl_q && !sda_q && sda) begin
				active  <= 1'b0;
				tx      <= 1'b0;
				sda_low <= 1'b0;
			end else if (active && scl && !scl_q) begin
				if (bit_cnt == 4'd8)
					master_ack <= !sda;
				else if (!tx)
					shift <= {shift[6:0], sda};
			end else if (active && !scl && scl_q) begin
				if (bit_cnt == 4'd7) begin
					bit_cnt <= 4'd8;
					if (tx) begin
						sda_low <= 1'b0;
					end else if (addr_phase && (shift[7:1] != `NUNCHUK_ADDR || !present)) begin
						// Stay off the bus until the next start when not addressed
						active <= 1'b0;
					end else begin
						sda_low  <= 1'b1;
						wr_valid <= 1'b1;
						wr_data  <= shift;
						if (addr_phase && shift[0])
							read_progs <= read_progs + 1;
					end
				end else if (bit_cnt == 4'd8) begin
					bit_cnt    <= 4'd0;
					addr_phase <= 1'b0;
					if (addr_phase && shift[0]) begin
						tx      <= 1'b1;
						shift   <= data[0];
						sda_low <= !data[0][7];
						rd_idx  <= 3'd1;
					end else if (tx && master_ack && rd_idx < BYTE_END) begin
						shift   <= data[rd_idx];
						sda_low <= !data[rd_idx][7];
						rd_idx  <= rd_idx + 3'd1;
					end else begin
						tx      <= 1'b0;
						sda_low <= 1'b0;
					end
				end else begin
					bit_cnt <= bit_cnt + 4'd1;
					if (tx) begin
						sda_low <= !shift[6];
						shift   <= {shift[6:0], 1'b0};
					end
				end
			end
		end
	end

endmodule

//--- tb_top.sv
`include "nunchuk_defines.svh"

module tb_top
	import nunchuk_pkg::*;
();

	localparam int PERIOD = 100;
	localparam int SAMPLES = 21;
	localparam int SAMPLE_W = 8 * `READ_BYTES;
	// Upper bound of one program with every slot counted as a full byte
	localparam int PROG_CYCLES = `CMD_SLOTS * (36 * `I2C_CLK_DIV + 2);
	localparam logic [7:0] ADDR_WR = {`NUNCHUK_ADDR, 1'b0};

	logic clk;
	logic rst;
	logic present;
	logic [7:0] md [`READ_BYTES];
	logic scl;
	logic dut_sda_low;
	logic model_sda_low;
	logic sda_in;
	logic [JOY_W-1:0] joy_x;
	logic [JOY_W-1:0] joy_y;
	logic [ACC_W-1:0] acc_x;
	logic [ACC_W-1:0] acc_y;
	logic [ACC_W-1:0] acc_z;
	logic button_c;
	logic button_z;
	logic sample_valid;
	logic wr_valid;
	logic [7:0] wr_data;
	int read_progs;
	int sample_count;
	logic [31:0] rng;
	logic [SAMPLE_W-1:0] exp_q [$];
	logic [7:0] log_q [$];

	// Pull-up wins unless a side pulls low
	assign sda_in = !(dut_sda_low === 1'b1) && !(model_sda_low === 1'b1);

	nunchuk_top DUT (
		.clk          (clk),
		.rst          (rst),
		.sda_in       (sda_in),
		.scl          (scl),
		.sda_low      (dut_sda_low),
		.joy_x        (joy_x),
		.joy_y        (joy_y),
		.acc_x        (acc_x),
		.acc_y        (acc_y),
		.acc_z        (acc_z),
		.button_c     (button_c),
		.button_z     (button_z),
		.sample_valid (sample_valid)
	);

	nunchuk_model model (
		.clk        (clk),
		.rst        (rst),
		.scl        (scl),
		.sda        (sda_in),
		.present    (present),
		.data       (md),
		.sda_low    (model_sda_low),
		.wr_valid   (wr_valid),
		.wr_data    (wr_data),
		.read_progs (read_progs)
	);

	initial clk = 1'b0;
	always #(PERIOD / 2) clk = ~clk;

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Test FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic joy_match(input string name, input logic [JOY_W-1:0] got,
			input logic [JOY_W-1:0] exp);
		if (got !== exp)
			abort_run($sformatf("ERROR at %0t: %s got %h expected %h", $time, name, got, exp));
	endtask

	task automatic acc_match(input string name, input logic [ACC_W-1:0] got,
			input logic [ACC_W-1:0] exp);
		if (got !== exp)
			abort_run($sformatf("ERROR at %0t: %s got %h expected %h", $time, name, got, exp));
	endtask

	task automatic bit_match(input string name, input logic got, input logic exp);
		if (got !== exp)
			abort_run($sformatf("ERROR at %0t: %s got %b expected %b", $time, name, got, exp));
	endtask

	task automatic log_match(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp)
			abort_run($sformatf("ERROR at %0t: %s got %h expected %h", $time, name, got, exp));
	endtask

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] s;
		s = x ^ (x << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	// Byte 0 sits in the top bits of the packed sample
	function automatic void decode_ref(
		input  logic [SAMPLE_W-1:0] b,
		output logic [JOY_W-1:0] jx,
		output logic [JOY_W-1:0] jy,
		output logic [ACC_W-1:0] ax,
		output logic [ACC_W-1:0] ay,
		output logic [ACC_W-1:0] az,
		output logic c,
		output logic z
	);
		logic [7:0] by [`READ_BYTES];
		for (int i = 0; i < `READ_BYTES; i++)
			by[i] = b[SAMPLE_W - 1 - 8 * i -: 8];
		jx = by[0];
		jy = by[1];
		ax = {by[2], by[5][3:2]};
		ay = {by[3], by[5][5:4]};
		az = {by[4], by[5][7:6]};
		c = !by[5][1];
		z = !by[5][0];
	endfunction

	task automatic load_bytes();
		logic [SAMPLE_W-1:0] v;
		for (int i = 0; i < `READ_BYTES; i++) begin
			rng = xorshift(rng);
			md[i] <= rng[7:0];
			v[SAMPLE_W - 1 - 8 * i -: 8] = rng[7:0];
		end
		exp_q.push_back(v);
	endtask

	task automatic wait_sample();
		do
			@(negedge clk);
		while (sample_valid !== 1'b1);
		@(posedge clk);
	endtask

	task automatic handshake_logged(input string when);
		logic [7:0] hs [6];
		hs = '{ADDR_WR, 8'hf0, 8'h55, ADDR_WR, 8'hfb, 8'h00};
		if (log_q.size() < 6)
			abort_run({"Handshake writes missing ", when});
		for (int i = 0; i < 6; i++)
			log_match($sformatf("write log entry %0d", i), log_q[i], hs[i]);
	endtask

	always @(negedge clk) begin
		if (wr_valid === 1'b1)
			log_q.push_back(wr_data);
	end

	always @(negedge clk) begin : compare_sample
		logic [SAMPLE_W-1:0] exp_bytes;
		logic [JOY_W-1:0] ex_jx;
		logic [JOY_W-1:0] ex_jy;
		logic [ACC_W-1:0] ex_ax;
		logic [ACC_W-1:0] ex_ay;
		logic [ACC_W-1:0] ex_az;
		logic ex_c;
		logic ex_z;
		if (rst === 1'b0 && sample_valid === 1'b1) begin
			if (exp_q.size() == 0) begin
				abort_run("A sample was published although no read program was expected");
			end else begin
				exp_bytes = exp_q.pop_front();
				decode_ref(exp_bytes, ex_jx, ex_jy, ex_ax, ex_ay, ex_az, ex_c, ex_z);
				joy_match("joy_x", joy_x, ex_jx);
				joy_match("joy_y", joy_y, ex_jy);
				acc_match("acc_x", acc_x, ex_ax);
				acc_match("acc_y", acc_y, ex_ay);
				acc_match("acc_z", acc_z, ex_az);
				bit_match("button_c", button_c, ex_c);
				bit_match("button_z", button_z, ex_z);
				sample_count = sample_count + 1;
			end
		end
	end

	initial begin : stimulus
		int drop_count;
		rst = 1'b1;
		present = 1'b1;
		rng = 32'hc91e;
		sample_count = 0;
		for (int i = 0; i < `READ_BYTES; i++)
			md[i] = 8'h00;
		repeat (16) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		bit_match("scl", scl, 1'b1);
		bit_match("sda_low", dut_sda_low, 1'b0);
		bit_match("sample_valid", sample_valid, 1'b0);

		@(posedge clk);
		load_bytes();
		wait_sample();
		handshake_logged("before the first sample");
		repeat (SAMPLES - 1) begin
			load_bytes();
			wait_sample();
		end
		if (sample_count != read_progs)
			abort_run("Sample count differs from the read programs seen by the model");

		// The read program now starting ends on the released line
		drop_count = sample_count;
		present <= 1'b0;
		exp_q.push_back({SAMPLE_W{1'b1}});
		repeat (4 * PROG_CYCLES) @(posedge clk);
		if (sample_count != drop_count + 1)
			abort_run("Wrong number of samples while the model ignored its address");

		present <= 1'b1;
		log_q.delete();
		load_bytes();
		wait_sample();
		handshake_logged("after the model returned");
		if (sample_count != read_progs + 1) begin
			abort_run("Sample count differs from the read programs seen by the model");
		end else begin
			$display("Test OK");
			$finish;
		end
	end

	initial begin : watchdog
		#(40 * PROG_CYCLES * PERIOD);
		abort_run("Timeout: the test sequence did not complete in time");
	end

endmodule

//--- tb.f
+incdir+.
i2c_pkg.sv
nunchuk_pkg.sv
i2c_master.sv
nunchuk_sequencer.sv
nunchuk_decoder.sv
nunchuk_top.sv
nunchuk_model.sv
tb_top.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f tb.f --top-module tb_top -o tb_sim > build.log 2>&1 \
	|| { cat build.log; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1
cat sim.log
grep -q "Test FAILED" sim.log && exit 1
grep -q "Test OK" sim.log || exit 1
exit 0
